/* verilog.f */
noc_flit_pkg.sv
noc_topology_pkg.sv
vc_fifo.sv
round_robin_arbiter.sv
vc_input_port.sv
ejection_arbiter.sv
spidergon_route_stage.sv
spidergon_node.sv
tb_spidergon_node.sv

/* Makefile */
# Verilator build and run for the Spidergon node testbench

VERILATOR ?= verilator
TOP ?= tb_spidergon_node
LINT_TOP ?= spidergon_node
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Simulation finished: PASS
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, a missing pass line makes grep fail the target
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_spidergon_node.sv */
// testbench for the Spidergon node with stimulus tasks, reference model, assertions and reporting
`timescale 1ns/1ps

module tb_spidergon_node;

	localparam int node_id = 0;
	localparam int num_ports = noc_topology_pkg::num_ports;
	localparam int num_vcs = noc_flit_pkg::num_vcs;
	localparam int num_ids = 16;
	localparam int timeout_cycles = 200;

	logic clk;
	logic reset;
	noc_topology_pkg::link_t [num_ports-1:0] link_in;
	noc_topology_pkg::link_t [num_ports-1:0] link_out;
	logic [num_ports*num_vcs-1:0] vc_ready;
	logic [num_ports*num_vcs-1:0] vc_full;
	noc_topology_pkg::link_t cpu_in;
	noc_topology_pkg::link_t cpu_out;

	// injection model, predicted at the drive edge and registered so it lines up with link_out
	noc_topology_pkg::link_t [num_ports-1:0] predicted_links;
	noc_topology_pkg::link_t [num_ports-1:0] expected_links;
	int held_dir;

	// ejection model keeps one queue of outstanding flits per packet id
	noc_flit_pkg::flit_t expected_q [num_ids][$];
	noc_flit_pkg::flit_t eject_expected;
	int open_next [num_ports];
	int expected_open [num_ports];
	logic reset_check;

	int seed;
	int next_id;
	int error_count;
	int tests_run;
	int tests_failed;

	spidergon_node
	#(
		.node_id(noc_topology_pkg::node_id_t'(node_id)),
		.vc_depth(2)
	)
	spidergon_node_i
	(
		.clk(clk),
		.reset(reset),
		.link_in(link_in),
		.link_out(link_out),
		.vc_ready(vc_ready),
		.vc_full(vc_full),
		.cpu_in(cpu_in),
		.cpu_out(cpu_out)
	);

	always #50 clk = ~clk;

	// link_out and the reservation state both show one edge after the flit was driven
	always @(posedge clk)
	begin
		if (reset)
		begin
			expected_links <= '0;
			expected_open <= '{default: 0};
		end
		else
		begin
			expected_links <= predicted_links;
			expected_open <= open_next;
		end
	end

	// the packet id inside the ejected flit picks the queue whose front it must match
	always @(negedge clk)
	begin
		int id;
		if (!reset && cpu_out.valid)
		begin
			id = packet_id(cpu_out.flit);
			if (expected_q[id].size() > 0)
				eject_expected = expected_q[id].pop_front();
			else
				eject_expected = ~cpu_out.flit;
		end
	end

	assert property (@(posedge clk) disable iff (reset) link_out == expected_links)
		else
		begin
			$display("ERROR link_out expected %h got %h", $sampled(expected_links),
				$sampled(link_out));
			error_count++;
		end

	assert property (@(posedge clk) disable iff (reset)
		!cpu_out.valid || (cpu_out.flit == eject_expected))
		else
		begin
			$display("ERROR cpu_out.flit expected %h got %h", $sampled(eject_expected),
				$sampled(cpu_out.flit));
			error_count++;
		end

	assert property (@(posedge clk) disable iff (reset) !reset_check || (vc_full == '0))
		else
		begin
			$display("ERROR vc_full expected %h got %h", 6'h00, $sampled(vc_full));
			error_count++;
		end

	assert property (@(posedge clk) disable iff (reset) !reset_check || !cpu_out.valid)
		else
		begin
			$display("ERROR cpu_out.valid expected %h got %h", 1'b0, $sampled(cpu_out.valid));
			error_count++;
		end

	// each open packet holds exactly one VC of its link, so ready drops once per open packet
	for (genvar p = 0; p < num_ports; p++)
	begin : open_check_gen
		assert property (@(posedge clk) disable iff (reset)
			$countones(~vc_ready[p*num_vcs +: num_vcs]) == expected_open[p])
			else
			begin
				$display("ERROR vc_ready port %0d reserved count expected %h got %h", p,
					$sampled(expected_open[p]),
					$countones(~$sampled(vc_ready[p*num_vcs +: num_vcs])));
				error_count++;
			end
	end

	// ring distance decides the link, -1 stands for stop
	function automatic int expected_port(input logic [2:0] dest);
		int distance;
		distance = (int'(dest) - node_id + noc_topology_pkg::num_nodes) %
			noc_topology_pkg::num_nodes;
		if (distance == 0)
			return -1;
		if (distance <= 2)
			return int'(noc_topology_pkg::dir_clockwise);
		if (distance >= 6)
			return int'(noc_topology_pkg::dir_anticlockwise);
		return int'(noc_topology_pkg::dir_across);
	endfunction

	// the top four payload bits carry the packet id in both flit views
	function automatic int packet_id(input noc_flit_pkg::flit_t flit);
		noc_flit_pkg::head_body_t head_view;
		noc_flit_pkg::data_body_t data_view;
		head_view = noc_flit_pkg::head_body_t'(flit.body);
		data_view = noc_flit_pkg::data_body_t'(flit.body);
		if (flit.kind == noc_flit_pkg::kind_head || flit.kind == noc_flit_pkg::kind_header)
			return int'(head_view.payload[11:8]);
		return int'(data_view.payload[14:11]);
	endfunction

	function automatic noc_flit_pkg::flit_t make_head(input noc_flit_pkg::flit_kind_e kind,
		input logic tag, input logic [2:0] dest, input int id, input logic [7:0] payload);
		noc_flit_pkg::head_body_t view;
		noc_flit_pkg::flit_t flit;
		view.prev_vc = tag;
		view.dest = dest;
		view.payload = {4'(id), payload};
		flit.kind = kind;
		flit.body = view;
		return flit;
	endfunction

	function automatic noc_flit_pkg::flit_t make_data(input noc_flit_pkg::flit_kind_e kind,
		input logic tag, input int id, input logic [10:0] payload);
		noc_flit_pkg::data_body_t view;
		noc_flit_pkg::flit_t flit;
		view.prev_vc = tag;
		view.payload = {4'(id), payload};
		flit.kind = kind;
		flit.body = view;
		return flit;
	endfunction

	// a head or header picks the link from its destination, body and tail reuse the head's
	task automatic inject_flit(input noc_flit_pkg::flit_t flit);
		noc_flit_pkg::head_body_t head_view;
		int dir;
		head_view = noc_flit_pkg::head_body_t'(flit.body);
		@(negedge clk);
		cpu_in.valid = 1'b1;
		cpu_in.flit = flit;
		if (flit.kind == noc_flit_pkg::kind_head || flit.kind == noc_flit_pkg::kind_header)
			dir = expected_port(head_view.dest);
		else
			dir = held_dir;
		if (flit.kind == noc_flit_pkg::kind_head)
			held_dir = dir;
		else if (flit.kind == noc_flit_pkg::kind_tail)
			held_dir = -1;
		predicted_links = '0;
		if (dir >= 0)
		begin
			predicted_links[dir].valid = 1'b1;
			predicted_links[dir].flit = flit;
		end
	endtask

	task automatic inject_idle();
		@(negedge clk);
		cpu_in = '0;
		predicted_links = '0;
	endtask

	task automatic inject_packet(input logic [2:0] dest, input int bodies);
		logic [31:0] r;
		r = $random(seed);
		inject_flit(make_head(noc_flit_pkg::kind_head, 1'b0, dest, 0, r[7:0]));
		for (int b = 0; b < bodies; b++)
		begin
			r = $random(seed);
			inject_flit(make_data(noc_flit_pkg::kind_body, 1'b0, 0, r[10:0]));
		end
		r = $random(seed);
		inject_flit(make_data(noc_flit_pkg::kind_tail, 1'b0, 0, r[10:0]));
		inject_idle();
	endtask

	// both VCs must have room, and a head also needs an unreserved VC
	function automatic logic link_has_room(input int port, input logic head_like);
		if (vc_full[port*num_vcs +: num_vcs] != '0)
			return 1'b0;
		return !head_like || (vc_ready[port*num_vcs +: num_vcs] != '0);
	endfunction

	task automatic send_link_flit(input int port, input noc_flit_pkg::flit_t flit);
		int waited;
		logic head_like;
		waited = 0;
		head_like = (flit.kind == noc_flit_pkg::kind_head) ||
			(flit.kind == noc_flit_pkg::kind_header);
		@(negedge clk);
		while (!link_has_room(port, head_like))
		begin
			link_in[port] = '0;
			waited++;
			if (waited >= timeout_cycles)
				stop_on_timeout($sformatf("room on input link %0d", port));
			@(negedge clk);
		end
		link_in[port].valid = 1'b1;
		link_in[port].flit = flit;
		expected_q[packet_id(flit)].push_back(flit);
		if (flit.kind == noc_flit_pkg::kind_head)
			open_next[port]++;
		else if (flit.kind == noc_flit_pkg::kind_tail)
			open_next[port]--;
	endtask

	task automatic link_idle(input int port);
		@(negedge clk);
		link_in[port] = '0;
	endtask

	task automatic send_packet(input int port, input logic tag, input int bodies,
		input logic header_only);
		int id;
		logic [31:0] r;
		id = next_id;
		next_id = (next_id + 1) % num_ids;
		r = $random(seed);
		if (header_only)
			send_link_flit(port, make_head(noc_flit_pkg::kind_header, tag, r[10:8], id, r[7:0]));
		else
		begin
			send_link_flit(port, make_head(noc_flit_pkg::kind_head, tag, r[10:8], id, r[7:0]));
			for (int b = 0; b < bodies; b++)
			begin
				r = $random(seed);
				send_link_flit(port, make_data(noc_flit_pkg::kind_body, tag, id, r[10:0]));
			end
			r = $random(seed);
			send_link_flit(port, make_data(noc_flit_pkg::kind_tail, tag, id, r[10:0]));
		end
	endtask

	// random tag, length and kind, one packet open at a time on this link
	task automatic stream_packets(input int port, input int count);
		logic [31:0] r;
		for (int n = 0; n < count; n++)
		begin
			r = $random(seed);
			send_packet(port, r[0], int'(r[2:1]), r[5:3] == 3'd0);
		end
		link_idle(port);
	endtask

	function automatic logic model_empty();
		for (int i = 0; i < num_ids; i++)
		begin
			if (expected_q[i].size() != 0)
				return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (!model_empty())
		begin
			@(negedge clk);
			waited++;
			if (waited >= timeout_cycles)
				stop_on_timeout("every expected flit at cpu_out");
		end
		// lets the checks of the last ejected flit run
		repeat (2) @(negedge clk);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before)
			$display("test %s: pass", name);
		else
		begin
			tests_failed++;
			$display("test %s: fail, %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic report_and_finish();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout after %0d cycles while waiting for %s", timeout_cycles, what);
		error_count++;
		report_and_finish();
	endtask

	initial
	begin
		int errors_before;
		int ida;
		int idb;
		clk = 1'b0;
		reset = 1'b1;
		link_in = '0;
		cpu_in = '0;
		predicted_links = '0;
		held_dir = -1;
		eject_expected = '0;
		open_next = '{default: 0};
		reset_check = 1'b0;
		seed = 59175;
		next_id = 0;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// idle node right after reset
		errors_before = error_count;
		reset_check = 1'b1;
		repeat (4) @(negedge clk);
		reset_check = 1'b0;
		finish_test("reset state", errors_before);

		// one packet per destination plus a header, the link follows the ring distance
		errors_before = error_count;
		for (int d = 1; d < noc_topology_pkg::num_nodes; d++)
			inject_packet(3'(d), 2);
		inject_flit(make_head(noc_flit_pkg::kind_header, 1'b0, 3'd5, 0, 8'h5a));
		inject_idle();
		repeat (2) @(negedge clk);
		finish_test("injection routing", errors_before);

		errors_before = error_count;
		inject_packet(3'(node_id), 1);
		inject_flit(make_head(noc_flit_pkg::kind_header, 1'b0, 3'(node_id), 0, 8'ha5));
		inject_idle();
		repeat (2) @(negedge clk);
		finish_test("discard to self", errors_before);

		errors_before = error_count;
		send_packet(0, 1'b1, 3, 1'b0);
		link_idle(0);
		wait_drained();
		finish_test("single packet ejection", errors_before);

		// two tags on one link keep both VCs reserved at once
		errors_before = error_count;
		ida = next_id;
		idb = next_id + 1;
		next_id = (next_id + 2) % num_ids;
		send_link_flit(1, make_head(noc_flit_pkg::kind_head, 1'b0, 3'd0, ida, 8'h11));
		send_link_flit(1, make_head(noc_flit_pkg::kind_head, 1'b1, 3'd0, idb, 8'h22));
		for (int b = 0; b < 3; b++)
		begin
			send_link_flit(1, make_data(noc_flit_pkg::kind_body, 1'b0, ida, 11'(b)));
			send_link_flit(1, make_data(noc_flit_pkg::kind_body, 1'b1, idb, 11'(b + 8)));
		end
		send_link_flit(1, make_data(noc_flit_pkg::kind_tail, 1'b0, ida, 11'h7ff));
		send_link_flit(1, make_data(noc_flit_pkg::kind_tail, 1'b1, idb, 11'h400));
		link_idle(1);
		wait_drained();
		finish_test("interleaved packets", errors_before);

		errors_before = error_count;
		next_id = 0;
		fork
			stream_packets(0, 4);
			stream_packets(1, 4);
			stream_packets(2, 4);
		join
		wait_drained();
		finish_test("concurrent traffic", errors_before);

		report_and_finish();
	end

endmodule

/* spidergon_node.sv */
// Spidergon node top level with three input ports, CPU ejection and injection routing
`timescale 1ns/1ps

module spidergon_node
#(
	parameter noc_topology_pkg::node_id_t node_id = '0,
	parameter int vc_depth = 2
)
(
	input logic clk,
	input logic reset,
	input noc_topology_pkg::link_t [noc_topology_pkg::num_ports-1:0] link_in,
	output noc_topology_pkg::link_t [noc_topology_pkg::num_ports-1:0] link_out,
	output logic [noc_topology_pkg::num_ports*noc_flit_pkg::num_vcs-1:0] vc_ready,
	output logic [noc_topology_pkg::num_ports*noc_flit_pkg::num_vcs-1:0] vc_full,
	input noc_topology_pkg::link_t cpu_in,
	output noc_topology_pkg::link_t cpu_out
);

	localparam int num_ports = noc_topology_pkg::num_ports;
	localparam int num_vcs = noc_flit_pkg::num_vcs;

	// VC heads of every port and the strobes that drain them
	noc_flit_pkg::flit_t [num_ports-1:0][num_vcs-1:0] vc_flit;
	logic [num_ports*num_vcs-1:0] vc_not_empty;
	logic [num_ports*num_vcs-1:0] dequeue;

	// port index follows the direction encoding, anticlockwise first
	for (genvar p = 0; p < num_ports; p++)
	begin : input_port_gen
		vc_input_port
		#(
			.vc_depth(vc_depth)
		)
		vc_input_port_i
		(
			.clk(clk),
			.reset(reset),
			.link(link_in[p]),
			.dequeue(dequeue[p*num_vcs +: num_vcs]),
			.vc_flit(vc_flit[p]),
			.vc_not_empty(vc_not_empty[p*num_vcs +: num_vcs]),
			.ready(vc_ready[p*num_vcs +: num_vcs]),
			.full(vc_full[p*num_vcs +: num_vcs])
		);
	end

	// all received traffic ends at the local CPU
	ejection_arbiter ejection_arbiter_i
	(
		.clk(clk),
		.reset(reset),
		.vc_flit(vc_flit),
		.vc_not_empty(vc_not_empty),
		.dequeue(dequeue),
		.cpu_out(cpu_out)
	);

	// CPU traffic is routed onto the output links
	spidergon_route_stage
	#(
		.node_id(node_id)
	)
	spidergon_route_stage_i
	(
		.clk(clk),
		.reset(reset),
		.cpu_in(cpu_in),
		.link_out(link_out)
	);

endmodule

/* spidergon_route_stage.sv */
// Spidergon route computation for CPU flits, per-packet route hold and registered output links
`timescale 1ns/1ps

module spidergon_route_stage
#(
	parameter noc_topology_pkg::node_id_t node_id = '0
)
(
	input logic clk,
	input logic reset,
	input noc_topology_pkg::link_t cpu_in,
	output noc_topology_pkg::link_t [noc_topology_pkg::num_ports-1:0] link_out
);

	// a quarter of the ring is reached along the ring, the rest goes across first
	localparam int quarter = noc_topology_pkg::num_nodes / 4;

	noc_flit_pkg::head_body_t head_view;
	noc_topology_pkg::port_e head_dir;
	noc_topology_pkg::port_e held_dir;
	noc_topology_pkg::port_e out_dir;
	logic head_like;

	// distance is taken modulo the ring size by the natural wrap of node_id_t
	function automatic noc_topology_pkg::port_e route(input noc_topology_pkg::node_id_t dest);
		noc_topology_pkg::node_id_t distance;
		distance = dest - node_id;
		if (distance == '0)
			return noc_topology_pkg::dir_stop;
		if (int'(distance) <= quarter)
			return noc_topology_pkg::dir_clockwise;
		if (int'(distance) >= noc_topology_pkg::num_nodes - quarter)
			return noc_topology_pkg::dir_anticlockwise;
		return noc_topology_pkg::dir_across;
	endfunction

	assign head_view = noc_flit_pkg::head_body_t'(cpu_in.flit.body);
	assign head_dir = route(noc_topology_pkg::node_id_t'(head_view.dest));
	assign head_like = (cpu_in.flit.kind == noc_flit_pkg::kind_head) ||
		(cpu_in.flit.kind == noc_flit_pkg::kind_header);

	// body and tail carry no destination and reuse what their head chose
	assign out_dir = head_like ? head_dir : held_dir;

	// a head opens the route and a tail closes it
	// a header is a whole packet and leaves the latch alone
	always_ff @(posedge clk)
	begin
		if (reset)
			held_dir <= noc_topology_pkg::dir_stop;
		else if (cpu_in.valid && (cpu_in.flit.kind == noc_flit_pkg::kind_head))
			held_dir <= head_dir;
		else if (cpu_in.valid && (cpu_in.flit.kind == noc_flit_pkg::kind_tail))
			held_dir <= noc_topology_pkg::dir_stop;
	end

	// stop matches no link, so traffic for this node itself goes nowhere
	for (genvar p = 0; p < noc_topology_pkg::num_ports; p++)
	begin : link_gen
		logic selected;

		assign selected = cpu_in.valid && (out_dir == noc_topology_pkg::port_e'(p));

		always_ff @(posedge clk)
		begin
			if (reset)
				link_out[p].valid <= 1'b0;
			else
				link_out[p].valid <= selected;
			// unused links carry an all-zero flit
			link_out[p].flit <= selected ? cpu_in.flit : '0;
		end
	end

endmodule

/* ejection_arbiter.sv */
// port and VC round-robin arbitration toward the CPU and the registered CPU output
`timescale 1ns/1ps

module ejection_arbiter
(
	input logic clk,
	input logic reset,
	input noc_flit_pkg::flit_t [noc_topology_pkg::num_ports-1:0][noc_flit_pkg::num_vcs-1:0] vc_flit,
	input logic [noc_topology_pkg::num_ports*noc_flit_pkg::num_vcs-1:0] vc_not_empty,
	output logic [noc_topology_pkg::num_ports*noc_flit_pkg::num_vcs-1:0] dequeue,
	output noc_topology_pkg::link_t cpu_out
);

	localparam int num_ports = noc_topology_pkg::num_ports;
	localparam int num_vcs = noc_flit_pkg::num_vcs;

	logic [num_ports-1:0] port_request;
	logic [num_ports-1:0] port_grant;
	logic [num_ports-1:0][num_vcs-1:0] vc_grant;
	noc_flit_pkg::flit_t selected_flit;

	// a port competes when any of its VCs holds a flit
	for (genvar p = 0; p < num_ports; p++)
	begin : port_request_gen
		assign port_request[p] = |vc_not_empty[p*num_vcs +: num_vcs];
	end

	round_robin_arbiter
	#(
		.width(num_ports)
	)
	port_arbiter_i
	(
		.clk(clk),
		.reset(reset),
		.request(port_request),
		.grant(port_grant)
	);

	// the VC arbiter of a port only sees requests in cycles its port won,
	// so its priority moves only when that port is served
	for (genvar p = 0; p < num_ports; p++)
	begin : vc_arbiter_gen
		round_robin_arbiter
		#(
			.width(num_vcs)
		)
		vc_arbiter_i
		(
			.clk(clk),
			.reset(reset),
			.request(vc_not_empty[p*num_vcs +: num_vcs] & {num_vcs{port_grant[p]}}),
			.grant(vc_grant[p])
		);
	end

	// at most one VC in the whole node is granted, that grant is the dequeue strobe
	assign dequeue = vc_grant;

	// one-hot select, an idle cycle yields an all-zero flit
	always_comb
	begin
		selected_flit = '0;
		for (int p = 0; p < num_ports; p++)
		begin
			for (int v = 0; v < num_vcs; v++)
			begin
				if (vc_grant[p][v])
					selected_flit = vc_flit[p][v];
			end
		end
	end

	// flit leaves the FIFO at this edge and shows on cpu_out right after it
	always_ff @(posedge clk)
	begin
		if (reset)
			cpu_out.valid <= 1'b0;
		else
			cpu_out.valid <= |vc_grant;
		cpu_out.flit <= selected_flit;
	end

	// no back-pressure from the CPU, so stored traffic always drains one flit per cycle
	assert property (@(posedge clk) disable iff (reset) (|vc_not_empty) |=> cpu_out.valid)
		else $error("ejection_arbiter: pending flit not ejected");

endmodule

/* vc_input_port.sv */
// input link classification, VC reservation table and the two VC FIFOs of one link
`timescale 1ns/1ps

module vc_input_port
#(
	parameter int vc_depth = 2
)
(
	input logic clk,
	input logic reset,
	input noc_topology_pkg::link_t link,
	input logic [noc_flit_pkg::num_vcs-1:0] dequeue,
	output noc_flit_pkg::flit_t [noc_flit_pkg::num_vcs-1:0] vc_flit,
	output logic [noc_flit_pkg::num_vcs-1:0] vc_not_empty,
	output logic [noc_flit_pkg::num_vcs-1:0] ready,
	output logic [noc_flit_pkg::num_vcs-1:0] full
);

	// one row of the reservation table
	// tag is the upstream VC whose packet owns this VC while reserved is set
	typedef struct packed
	{
		logic reserved;
		noc_flit_pkg::vc_tag_t tag;
	} vc_entry_t;

	vc_entry_t [noc_flit_pkg::num_vcs-1:0] vc_table;

	noc_flit_pkg::flit_kind_e kind;
	noc_flit_pkg::head_body_t head_view;
	noc_flit_pkg::data_body_t data_view;
	logic head_like;
	logic [noc_flit_pkg::num_vcs-1:0] free_request;
	logic [noc_flit_pkg::num_vcs-1:0] free_grant;
	logic [noc_flit_pkg::num_vcs-1:0] body_target;
	logic [noc_flit_pkg::num_vcs-1:0] target;
	logic [noc_flit_pkg::num_vcs-1:0] enqueue;
	logic [noc_flit_pkg::num_vcs-1:0] empty;

	// both views overlay the same 16 bits, only the kind tells which one is meant
	assign kind = link.flit.kind;
	assign head_view = noc_flit_pkg::head_body_t'(link.flit.body);
	assign data_view = noc_flit_pkg::data_body_t'(link.flit.body);

	// heads and headers both open a packet and need a free VC
	assign head_like = (kind == noc_flit_pkg::kind_head) || (kind == noc_flit_pkg::kind_header);

	// a VC is free when unreserved and it still has room
	// only ask when a head is really there, so priority rotates per packet
	assign free_request = ready & ~full & {noc_flit_pkg::num_vcs{link.valid && head_like}};

	round_robin_arbiter
	#(
		.width(noc_flit_pkg::num_vcs)
	)
	free_vc_arbiter_i
	(
		.clk(clk),
		.reset(reset),
		.request(free_request),
		.grant(free_grant)
	);

	// body and tail follow the VC reserved by their own upstream tag
	// the first match wins, an upstream VC never has two open packets
	always_comb
	begin
		body_target = '0;
		for (int v = 0; v < noc_flit_pkg::num_vcs; v++)
		begin
			if (vc_table[v].reserved && (vc_table[v].tag == data_view.prev_vc) &&
				(body_target == '0))
				body_target[v] = 1'b1;
		end
	end

	assign target = head_like ? free_grant : body_target;

	// a flit with no target or aimed at a full VC is dropped here
	assign enqueue = target & ~full & {noc_flit_pkg::num_vcs{link.valid}};

	// reservation and release land on the same edge that stores the flit
	// a header passes through a free VC and leaves it unreserved
	always_ff @(posedge clk)
	begin
		if (reset)
			vc_table <= '0;
		else
		begin
			for (int v = 0; v < noc_flit_pkg::num_vcs; v++)
			begin
				if (enqueue[v] && (kind == noc_flit_pkg::kind_head))
				begin
					vc_table[v].reserved <= 1'b1;
					vc_table[v].tag <= head_view.prev_vc;
				end
				else if (enqueue[v] && (kind == noc_flit_pkg::kind_tail))
					vc_table[v].reserved <= 1'b0;
			end
		end
	end

	for (genvar v = 0; v < noc_flit_pkg::num_vcs; v++)
	begin : vc_gen
		// upstream may only open a new packet on a VC that shows ready
		assign ready[v] = !vc_table[v].reserved;
		assign vc_not_empty[v] = !empty[v];

		vc_fifo
		#(
			.vc_depth(vc_depth)
		)
		vc_fifo_i
		(
			.clk(clk),
			.reset(reset),
			.enqueue(enqueue[v]),
			.enqueue_flit(link.flit),
			.dequeue(dequeue[v]),
			.dequeue_flit(vc_flit[v]),
			.full(full[v]),
			.empty(empty[v])
		);
	end

	// the sender broke the ready or full rule if a valid flit found no place
	assert property (@(posedge clk) disable iff (reset) link.valid |-> (enqueue != '0))
		else $error("vc_input_port: valid flit dropped, no free or matching VC");

endmodule

/* round_robin_arbiter.sv */
// rotating-priority arbiter with a one-hot grant
`timescale 1ns/1ps

module round_robin_arbiter
#(
	parameter int width = 2
)
(
	input logic clk,
	input logic reset,
	input logic [width-1:0] request,
	output logic [width-1:0] grant
);

	localparam int idx_w = $clog2(width);

	// index of the requester served last, it has the lowest priority next time
	logic [idx_w-1:0] last;
	logic [idx_w-1:0] winner;
	logic found;

	// search starts one past the last winner and wraps around
	always_comb
	begin
		int idx;
		grant = '0;
		winner = last;
		found = 1'b0;
		for (int i = 1; i <= width; i++)
		begin
			idx = (int'(last) + i) % width;
			if (!found && request[idx])
			begin
				grant[idx] = 1'b1;
				winner = idx_w'(idx);
				found = 1'b1;
			end
		end
	end

	// priority only rotates when someone is actually served
	always_ff @(posedge clk)
	begin
		if (reset)
			last <= idx_w'(width - 1);
		else if (found)
			last <= winner;
	end

	assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant) && ((grant & ~request) == '0))
		else $error("round_robin_arbiter: grant not one-hot or not requested");

endmodule

/* vc_fifo.sv */
// strict-order flit FIFO for one virtual channel with full and empty flags
`timescale 1ns/1ps

module vc_fifo
#(
	parameter int vc_depth = 2
)
(
	input logic clk,
	input logic reset,
	input logic enqueue,
	input noc_flit_pkg::flit_t enqueue_flit,
	input logic dequeue,
	output noc_flit_pkg::flit_t dequeue_flit,
	output logic full,
	output logic empty
);

	// pointers need at least one bit even for a single-entry buffer
	localparam int ptr_w = (vc_depth > 1) ? $clog2(vc_depth) : 1;
	localparam int count_w = $clog2(vc_depth + 1);

	noc_flit_pkg::flit_t storage [vc_depth];
	logic [ptr_w-1:0] read_ptr;
	logic [ptr_w-1:0] write_ptr;
	logic [count_w-1:0] count;
	logic do_enqueue;
	logic do_dequeue;

	// pointer step with wrap at the buffer depth, which need not be a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(vc_depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// a full buffer ignores writes and an empty one ignores reads
	assign do_enqueue = enqueue && !full;
	assign do_dequeue = dequeue && !empty;

	assign full = (count == count_w'(vc_depth));
	assign empty = (count == '0);

	// the oldest flit is always visible at the output
	assign dequeue_flit = storage[read_ptr];

	always_ff @(posedge clk)
	begin
		if (do_enqueue)
			storage[write_ptr] <= enqueue_flit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_enqueue)
				write_ptr <= next_ptr(write_ptr);
			if (do_dequeue)
				read_ptr <= next_ptr(read_ptr);
			// count only moves when exactly one side is active
			case ({do_enqueue, do_dequeue})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the input port must honour full and the ejection stage must honour empty
	assert property (@(posedge clk) disable iff (reset) enqueue |-> !full)
		else $error("vc_fifo: enqueue while full");
	assert property (@(posedge clk) disable iff (reset) dequeue |-> !empty)
		else $error("vc_fifo: dequeue while empty");

endmodule

/* noc_topology_pkg.sv */
// ring size, node number type, link direction encoding, port count and the link struct
package noc_topology_pkg;

	// eight nodes on the Spidergon ring
	localparam int num_nodes = 8;

	// node number, wide enough for every node on the ring
	typedef logic [$clog2(num_nodes)-1:0] node_id_t;

	// anticlockwise, clockwise and across links per node
	localparam int num_ports = 3;

	// link direction, the port index of a link equals its encoding
	// stop means the flit has reached its destination and leaves on no link
	typedef enum logic [1:0]
	{
		dir_anticlockwise = 2'd0,
		dir_clockwise     = 2'd1,
		dir_across        = 2'd2,
		dir_stop          = 2'd3
	} port_e;

	// one link: a valid strobe travelling with its flit
	typedef struct packed
	{
		logic valid;
		noc_flit_pkg::flit_t flit;
	} link_t;

endpackage

/* noc_flit_pkg.sv */
// flit kind encoding, packed flit type, head and data views of the body field, VC count and tag
package noc_flit_pkg;

	// two virtual channels behind every input link
	localparam int num_vcs = 2;

	// index of a VC, carried in every flit as the tag of the previous hop
	typedef logic [$clog2(num_vcs)-1:0] vc_tag_t;

	// kind sits in the two top bits of every flit
	// a header is a one-flit packet with no payload of its own
	typedef enum logic [1:0]
	{
		kind_tail   = 2'b00,
		kind_head   = 2'b01,
		kind_body   = 2'b10,
		kind_header = 2'b11
	} flit_kind_e;

	// the full 18-bit flit as it travels on a link
	typedef struct packed
	{
		flit_kind_e kind;
		logic [15:0] body;
	} flit_t;

	// head and header view of the body field
	// destination is a plain 3-bit node number here, the topology package gives it meaning
	typedef struct packed
	{
		vc_tag_t prev_vc;
		logic [2:0] dest;
		logic [11:0] payload;
	} head_body_t;

	// body and tail view, the tag stays at the same bit so both views agree on it
	typedef struct packed
	{
		vc_tag_t prev_vc;
		logic [14:0] payload;
	} data_body_t;

endpackage
